//--- Bender.yml
package:
  name: fpWriteback

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fpWritebackPkg.sv
      - verilog/fpResultIf.sv
      - verilog/recoveryIf.sv
      - verilog/fpRegisterWriteStage.sv
      - verilog/fpPhysRegFile.sv
      - verilog/activeListCompletion.sv
      - verilog/fpWritebackTop.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/fpWritebackTb.sv

//--- fpWritebackTop.f
+incdir+verilog
verilog/fpWritebackPkg.sv
verilog/fpResultIf.sv
verilog/recoveryIf.sv
verilog/fpRegisterWriteStage.sv
verilog/fpPhysRegFile.sv
verilog/activeListCompletion.sv
verilog/fpWritebackTop.sv
verif/fpWritebackTb.sv

//--- verif/fpWritebackTb.sv
/*
 * Table-driven testbench for the FP write-back slice, two lanes assumed.
 * Expected values come from a cycle model stepped once per table row.
 * Each row is checked at the falling edge after it is driven.
 */
`timescale 1ns/100ps
`include "fpWriteback_defs.svh"

module fpWritebackTb;
    import fpWritebackPkg::*;

    localparam int LANES = `FP_ISSUE_WIDTH;
    localparam int NUM_ROWS = 46;

    typedef struct packed {
        logic    valid;
        AlPtr    alPtr;
        FpRegNum dstReg;
        logic    writeReg;
        logic    dataValid;
    } LaneSpec;

    typedef struct packed {
        logic    stall;
        logic    clear;
        logic    recov;
        logic    flushAll;
        AlPtr    head;
        AlPtr    tail;
        logic    alloc;
        AlPtr    allocPtr;
        LaneSpec lane0;
        LaneSpec lane1;
        FpRegNum queryReg;
        AlPtr    queryAl;
    } RowSpec;

    // stall clear recov flushAll, head tail, alloc allocPtr,
    // lane {valid alPtr dstReg writeReg dataValid} x2, queryReg queryAl
    localparam RowSpec SPEC [NUM_ROWS] = '{
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 0,0},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 31,15},
        // Both lanes complete, then writeReg low
        '{0,0,0,0, 0,0, 0,0, '{1,1,3,1,1}, '{1,2,4,1,1}, 3,1},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 4,2},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 3,1},
        '{0,0,0,0, 0,0, 0,0, '{1,3,3,0,1}, '{0,0,0,0,0}, 4,2},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 3,3},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 3,3},
        // Replay results on allocated entries
        '{0,0,0,0, 0,0, 1,5, '{0,0,0,0,0}, '{0,0,0,0,0}, 6,5},
        '{0,0,0,0, 0,0, 1,8, '{1,5,6,1,0}, '{1,8,7,0,0}, 6,5},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 7,8},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 6,5},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 7,8},
        // Stall for three cycles with new inputs offered
        '{0,0,0,0, 0,0, 0,0, '{1,9,10,1,1}, '{0,0,0,0,0}, 10,9},
        '{1,0,0,0, 0,0, 0,0, '{1,10,11,1,1}, '{1,11,12,1,1}, 10,9},
        '{1,0,0,0, 0,0, 0,0, '{1,10,11,1,1}, '{1,11,12,1,1}, 11,10},
        '{1,0,0,0, 0,0, 0,0, '{1,10,11,1,1}, '{1,11,12,1,1}, 10,9},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 10,9},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 10,9},
        // Re-allocate shows the held result was written only once
        '{0,0,0,0, 0,0, 1,9, '{0,0,0,0,0}, '{0,0,0,0,0}, 11,10},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 10,9},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 10,9},
        // Clear
        '{0,0,0,0, 0,0, 0,0, '{1,11,13,1,1}, '{0,0,0,0,0}, 13,11},
        '{0,1,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 13,11},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 13,11},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 13,11},
        // Flush all
        '{0,0,0,0, 0,0, 0,0, '{1,12,14,1,1}, '{1,13,15,1,1}, 14,12},
        '{0,0,1,1, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 14,12},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 15,13},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 14,12},
        // Wrapping range 14 up to 2
        '{0,0,0,0, 0,0, 0,0, '{1,15,16,1,1}, '{1,4,17,1,1}, 16,15},
        '{0,0,1,0, 14,2, 0,0, '{1,14,18,1,1}, '{1,2,19,1,1}, 16,15},
        '{0,0,1,0, 14,2, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 17,4},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 18,14},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 19,2},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 16,15},
        // Empty range
        '{0,0,0,0, 0,0, 0,0, '{1,6,20,1,1}, '{1,7,21,1,1}, 20,6},
        '{0,0,1,0, 5,5, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 20,6},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 20,6},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 21,7},
        // Same target on both lanes
        '{0,0,0,0, 0,0, 0,0, '{1,0,22,1,1}, '{1,0,22,1,0}, 22,0},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 22,0},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 22,0},
        // Allocate meets a write to the same entry
        '{0,0,0,0, 0,0, 0,0, '{1,10,23,1,1}, '{0,0,0,0,0}, 23,10},
        '{0,0,0,0, 0,0, 1,10, '{0,0,0,0,0}, '{0,0,0,0,0}, 23,10},
        '{0,0,0,0, 0,0, 0,0, '{0,0,0,0,0}, '{0,0,0,0,0}, 23,10}
    };

    logic ctrl = 1'b0;
    logic reset, stall, clear;
    logic [LANES-1:0] resValid, resWriteReg, resDataValid;
    AlPtr [LANES-1:0] resAlPtr;
    FpRegNum [LANES-1:0] resDstReg;
    FpWord [LANES-1:0] resData;
    FFlags [LANES-1:0] resFlags;
    logic toRecoveryPhase, flushAll, alloc;
    AlPtr flushHead, flushTail, allocPtr, alQueryPtr;
    FpRegNum regReadNum;
    FpWord regReadData;
    ExecState alQueryState;
    FFlags alQueryFlags;

    // Row data and expected query results
    FpWord laneData [NUM_ROWS][LANES];
    FFlags laneFlags [NUM_ROWS][LANES];
    FpWord expData [NUM_ROWS];
    ExecState expState [NUM_ROWS];
    FFlags expFlags [NUM_ROWS];

    // Cycle model state
    FpWord modelReg [`FP_PHY_REGS];
    ExecState modelState [`AL_ENTRIES];
    FFlags modelFlags [`AL_ENTRIES];
    LaneSpec heldLane [LANES];
    FpWord heldData [LANES];
    FFlags heldFlags [LANES];

    logic [31:0] lfsr = 32'hd1750e98;
    int errors = 0;
    int checks = 0;

    always #10 ctrl = ~ctrl;

    fpWritebackTop fpWritebackTop_inst (.*);

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [63:0] randomBits(input int n);
        logic [63:0] bits;
        logic fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[62:0], fb};
        end
        return bits;
    endfunction

    function automatic LaneSpec pickLane(input RowSpec s, input int l);
        return (l == 0) ? s.lane0 : s.lane1;
    endfunction

    // Distance from head, modulo the list size
    function automatic logic inFlushWindow(input AlPtr head, input AlPtr tail, input AlPtr ptr);
        AlPtr span;
        AlPtr offset;
        span = tail - head;
        offset = ptr - head;
        return offset < span;
    endfunction

    // One rising edge with the inputs of row p held
    task automatic advanceModel(input int p);
        RowSpec s;
        logic flushed;
        s = SPEC[p];
        if (s.alloc) begin
            modelState[s.allocPtr] = EXEC_NOT_FINISHED;
            modelFlags[s.allocPtr] = '0;
        end
        for (int l = 0; l < LANES; l++) begin
            flushed = s.recov &&
                (s.flushAll || inFlushWindow(s.head, s.tail, heldLane[l].alPtr));
            if (heldLane[l].valid && !s.stall && !s.clear && !flushed) begin
                if (heldLane[l].writeReg) begin
                    modelReg[heldLane[l].dstReg] = heldData[l];
                end
                modelState[heldLane[l].alPtr] =
                    heldLane[l].dataValid ? EXEC_SUCCESS : EXEC_NOT_FINISHED;
                modelFlags[heldLane[l].alPtr] = heldFlags[l];
            end
        end
        if (!s.stall) begin
            for (int l = 0; l < LANES; l++) begin
                heldLane[l] = pickLane(s, l);
                heldData[l] = laneData[p][l];
                heldFlags[l] = laneFlags[p][l];
            end
        end
    endtask

    task automatic driveRow(input int r);
        RowSpec s;
        LaneSpec ln;
        s = SPEC[r];
        stall <= s.stall;
        clear <= s.clear;
        toRecoveryPhase <= s.recov;
        flushAll <= s.flushAll;
        flushHead <= s.head;
        flushTail <= s.tail;
        alloc <= s.alloc;
        allocPtr <= s.allocPtr;
        regReadNum <= s.queryReg;
        alQueryPtr <= s.queryAl;
        for (int l = 0; l < LANES; l++) begin
            ln = pickLane(s, l);
            resValid[l] <= ln.valid;
            resAlPtr[l] <= ln.alPtr;
            resDstReg[l] <= ln.dstReg;
            resWriteReg[l] <= ln.writeReg;
            resDataValid[l] <= ln.dataValid;
            resData[l] <= laneData[r][l];
            resFlags[l] <= laneFlags[r][l];
        end
    endtask

    task automatic checkRow(input int r);
        checks += 3;
        if (regReadData !== expData[r]) begin
            errors++;
            $display("mismatch at %0t: row %0d reg %0d read %h, expected %h",
                $time, r, SPEC[r].queryReg, regReadData, expData[r]);
        end
        if (alQueryState !== expState[r]) begin
            errors++;
            $display("mismatch at %0t: row %0d entry %0d state %0d, expected %0d",
                $time, r, SPEC[r].queryAl, alQueryState, expState[r]);
        end
        if (alQueryFlags !== expFlags[r]) begin
            errors++;
            $display("mismatch at %0t: row %0d entry %0d flags %b, expected %b",
                $time, r, SPEC[r].queryAl, alQueryFlags, expFlags[r]);
        end
    endtask

    initial begin
        logic [63:0] flagBits;
        reset = 1'b1;
        stall = 1'b0;
        clear = 1'b0;
        resValid = '0;
        resAlPtr = '0;
        resDstReg = '0;
        resWriteReg = '0;
        resDataValid = '0;
        resData = '0;
        resFlags = '0;
        toRecoveryPhase = 1'b0;
        flushAll = 1'b0;
        flushHead = '0;
        flushTail = '0;
        alloc = 1'b0;
        allocPtr = '0;
        regReadNum = '0;
        alQueryPtr = '0;

        // Random payloads, then expected values from the reset state on
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int l = 0; l < LANES; l++) begin
                laneData[r][l] = randomBits(64);
                flagBits = randomBits(5);
                laneFlags[r][l] = flagBits[4:0];
            end
        end
        for (int i = 0; i < `FP_PHY_REGS; i++) begin
            modelReg[i] = '0;
        end
        for (int e = 0; e < `AL_ENTRIES; e++) begin
            modelState[e] = EXEC_ALLOCATED_IDLE;
            modelFlags[e] = '0;
        end
        for (int l = 0; l < LANES; l++) begin
            heldLane[l] = '0;
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (r > 0) begin
                advanceModel(r - 1);
            end
            expData[r] = modelReg[SPEC[r].queryReg];
            expState[r] = modelState[SPEC[r].queryAl];
            expFlags[r] = modelFlags[SPEC[r].queryAl];
        end

        // Reset spans two rising edges, released with the first row
        @(posedge ctrl);
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge ctrl);
            reset <= 1'b0;
            driveRow(r);
            @(negedge ctrl);
            checkRow(r);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Reset, every row and some margin
    initial begin
        #((NUM_ROWS + 10) * 20);
        $display("Timeout: the run did not finish within %0d cycles", NUM_ROWS + 10);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- verilog/activeListCompletion.sv
/*
 * Completion state and exception flags per active-list entry.
 * Allocate marks an entry not finished; a lane write to the same
 * entry in the same cycle takes priority, highest lane last.
 */
`timescale 1ns/100ps
`include "fpWriteback_defs.svh"

module activeListCompletion (
    input  logic ctrl,
    input  logic reset,
    input  logic alloc,
    input  fpWritebackPkg::AlPtr allocPtr,
    input  logic [`FP_ISSUE_WIDTH-1:0] write,
    input  fpWritebackPkg::AlPtr [`FP_ISSUE_WIDTH-1:0] writePtr,
    input  fpWritebackPkg::ExecState [`FP_ISSUE_WIDTH-1:0] writeState,
    input  fpWritebackPkg::FFlags [`FP_ISSUE_WIDTH-1:0] writeFlags,
    input  fpWritebackPkg::AlPtr queryPtr,
    output fpWritebackPkg::ExecState queryState,
    output fpWritebackPkg::FFlags queryFlags
);
    import fpWritebackPkg::*;

    ExecState stateTable [`AL_ENTRIES];
    FFlags    flagTable [`AL_ENTRIES];

    always_ff @(posedge ctrl) begin
        if (reset) begin
            for (int e = 0; e < `AL_ENTRIES; e++) begin
                stateTable[e] <= EXEC_ALLOCATED_IDLE;
                flagTable[e]  <= '0;
            end
        end else begin
            // New entry waits for its result
            if (alloc) begin
                stateTable[allocPtr] <= EXEC_NOT_FINISHED;
                flagTable[allocPtr]  <= '0;
            end
            // Write-back results override the allocate
            for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
                if (write[i]) begin
                    stateTable[writePtr[i]] <= writeState[i];
                    flagTable[writePtr[i]]  <= writeFlags[i];
                end
            end
        end
    end

    // Observation port
    assign queryState = stateTable[queryPtr];
    assign queryFlags = flagTable[queryPtr];

endmodule

//--- verilog/fpPhysRegFile.sv
/*
 * FP physical register file, one write port per lane.
 * Same-register writes in one cycle resolve to the highest lane.
 * Read is asynchronous.
 */
`timescale 1ns/100ps
`include "fpWriteback_defs.svh"

module fpPhysRegFile (
    input  logic ctrl,
    input  logic reset,
    input  logic [`FP_ISSUE_WIDTH-1:0] we,
    input  fpWritebackPkg::FpRegNum [`FP_ISSUE_WIDTH-1:0] wrNum,
    input  fpWritebackPkg::FpWord [`FP_ISSUE_WIDTH-1:0] wrData,
    input  fpWritebackPkg::FpRegNum rdNum,
    output fpWritebackPkg::FpWord rdData
);
    import fpWritebackPkg::*;

    FpWord regs [`FP_PHY_REGS];

    always_ff @(posedge ctrl) begin
        if (reset) begin
            for (int r = 0; r < `FP_PHY_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Later lanes override earlier ones
            for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
                if (we[i]) begin
                    regs[wrNum[i]] <= wrData[i];
                end
            end
        end
    end

    assign rdData = regs[rdNum];

endmodule

//--- verilog/fpRegisterWriteStage.sv
/*
 * FP register write stage, one pipeline register per lane.
 * Stall holds the register and blocks writes; clear only blocks writes.
 * Flush levels are combinational and act on the current content.
 */
`timescale 1ns/100ps
`include "fpWriteback_defs.svh"

module fpRegisterWriteStage (
    input  logic ctrl,
    input  logic reset,
    input  logic stall,
    input  logic clear,
    fpResultIf.stage prev,
    recoveryIf.stage recovery,
    // Register file write side
    output logic [`FP_ISSUE_WIDTH-1:0] regWe,
    output fpWritebackPkg::FpRegNum [`FP_ISSUE_WIDTH-1:0] regNum,
    output fpWritebackPkg::FpWord [`FP_ISSUE_WIDTH-1:0] regData,
    // Active list completion side
    output logic [`FP_ISSUE_WIDTH-1:0] alWrite,
    output fpWritebackPkg::AlPtr [`FP_ISSUE_WIDTH-1:0] alWritePtr,
    output fpWritebackPkg::ExecState [`FP_ISSUE_WIDTH-1:0] alWriteState,
    output fpWritebackPkg::FFlags [`FP_ISSUE_WIDTH-1:0] alWriteFlags
);
    import fpWritebackPkg::*;

    FpStageReg [`FP_ISSUE_WIDTH-1:0] pipeReg;
    logic [`FP_ISSUE_WIDTH-1:0] flush;
    logic [`FP_ISSUE_WIDTH-1:0] update;

    // Selective flush check for one active-list pointer
    function automatic logic isFlushed(
        input logic toRecoveryPhase,
        input logic flushAll,
        input AlPtr head,
        input AlPtr tail,
        input AlPtr ptr
    );
        logic inRange;
        if (head <= tail) begin
            // Also covers the empty range
            inRange = (ptr >= head) && (ptr < tail);
        end else begin
            // Range wraps past the last entry
            inRange = (ptr >= head) || (ptr < tail);
        end
        return toRecoveryPhase && (flushAll || inRange);
    endfunction

    // Only valid bits are reset, payload just follows the input
    always_ff @(posedge ctrl) begin
        if (reset) begin
            for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
                pipeReg[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            pipeReg <= prev.nextStage;
        end
    end

    always_comb begin
        for (int i = 0; i < `FP_ISSUE_WIDTH; i++) begin
            flush[i] = isFlushed(
                recovery.toRecoveryPhase,
                recovery.flushAll,
                recovery.flushHead,
                recovery.flushTail,
                pipeReg[i].alPtr
            );
            update[i] = pipeReg[i].valid && !stall && !clear && !flush[i];

            // Register file
            regWe[i]   = update[i] && pipeReg[i].writeReg;
            regNum[i]  = pipeReg[i].dstReg;
            regData[i] = pipeReg[i].data;

            // Active list, replay when data is not valid
            alWrite[i]      = update[i];
            alWritePtr[i]   = pipeReg[i].alPtr;
            alWriteState[i] = pipeReg[i].dataValid ? EXEC_SUCCESS : EXEC_NOT_FINISHED;
            alWriteFlags[i] = pipeReg[i].fflags;
        end
    end

endmodule

//--- verilog/fpResultIf.sv
/*
 * Per-lane FP results entering the write stage.
 * Content is sampled by the stage only on unstalled edges.
 */
`timescale 1ns/100ps
`include "fpWriteback_defs.svh"

interface fpResultIf;
    import fpWritebackPkg::*;

    // One stage-register image per lane
    FpStageReg [`FP_ISSUE_WIDTH-1:0] nextStage;

    // Driven from the top-level ports
    modport producer (
        output nextStage
    );

    // Captured by the write stage
    modport stage (
        input nextStage
    );

endinterface

//--- verilog/fpWritebackPkg.sv
/*
 * Shared types for the FP write-back slice.
 * Widths follow the macros in fpWriteback_defs.svh.
 * Flags are ordered NV, DZ, OF, UF, NX from MSB to LSB.
 */
`include "fpWriteback_defs.svh"

package fpWritebackPkg;

    typedef logic [`AL_PTR_BITS-1:0] AlPtr;
    typedef logic [`FP_REG_BITS-1:0] FpRegNum;
    typedef logic [63:0] FpWord;

    // IEEE exception flags
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } FFlags;

    // Completion state of one active-list entry
    typedef enum logic [1:0] {
        EXEC_NOT_FINISHED   = 2'd0,
        EXEC_SUCCESS        = 2'd1,
        EXEC_ALLOCATED_IDLE = 2'd2
    } ExecState;

    // One lane of the write-stage pipeline register
    typedef struct packed {
        logic    valid;
        AlPtr    alPtr;
        FpRegNum dstReg;
        logic    writeReg;
        // Low when the op must be replayed
        logic    dataValid;
        FpWord   data;
        FFlags   fflags;
    } FpStageReg;

endpackage

//--- verilog/fpWritebackTop.sv
/*
 * FP write-back slice top level with plain ports.
 * Results land two edges after they are presented, stall permitting.
 * Query outputs are combinational from stored state.
 */
`timescale 1ns/100ps
`include "fpWriteback_defs.svh"

module fpWritebackTop (
    input  logic ctrl,
    input  logic reset,
    input  logic stall,
    input  logic clear,
    // Results from execution, one entry per lane
    input  logic [`FP_ISSUE_WIDTH-1:0] resValid,
    input  fpWritebackPkg::AlPtr [`FP_ISSUE_WIDTH-1:0] resAlPtr,
    input  fpWritebackPkg::FpRegNum [`FP_ISSUE_WIDTH-1:0] resDstReg,
    input  logic [`FP_ISSUE_WIDTH-1:0] resWriteReg,
    input  logic [`FP_ISSUE_WIDTH-1:0] resDataValid,
    input  fpWritebackPkg::FpWord [`FP_ISSUE_WIDTH-1:0] resData,
    input  fpWritebackPkg::FFlags [`FP_ISSUE_WIDTH-1:0] resFlags,
    // Recovery
    input  logic toRecoveryPhase,
    input  logic flushAll,
    input  fpWritebackPkg::AlPtr flushHead,
    input  fpWritebackPkg::AlPtr flushTail,
    // Allocate and query
    input  logic alloc,
    input  fpWritebackPkg::AlPtr allocPtr,
    input  fpWritebackPkg::FpRegNum regReadNum,
    input  fpWritebackPkg::AlPtr alQueryPtr,
    output fpWritebackPkg::FpWord regReadData,
    output fpWritebackPkg::ExecState alQueryState,
    output fpWritebackPkg::FFlags alQueryFlags
);
    import fpWritebackPkg::*;

    logic [`FP_ISSUE_WIDTH-1:0] regWe;
    FpRegNum [`FP_ISSUE_WIDTH-1:0] regNum;
    FpWord [`FP_ISSUE_WIDTH-1:0] regData;
    logic [`FP_ISSUE_WIDTH-1:0] alWrite;
    AlPtr [`FP_ISSUE_WIDTH-1:0] alWritePtr;
    ExecState [`FP_ISSUE_WIDTH-1:0] alWriteState;
    FFlags [`FP_ISSUE_WIDTH-1:0] alWriteFlags;

    fpResultIf resultBus ();
    recoveryIf recoveryBus ();

    // Pack the flat lane ports into stage-register images
    for (genvar i = 0; i < `FP_ISSUE_WIDTH; i++) begin : gPackLane
        assign resultBus.nextStage[i] = '{
            valid:     resValid[i],
            alPtr:     resAlPtr[i],
            dstReg:    resDstReg[i],
            writeReg:  resWriteReg[i],
            dataValid: resDataValid[i],
            data:      resData[i],
            fflags:    resFlags[i]
        };
    end

    assign recoveryBus.toRecoveryPhase = toRecoveryPhase;
    assign recoveryBus.flushAll        = flushAll;
    assign recoveryBus.flushHead       = flushHead;
    assign recoveryBus.flushTail       = flushTail;

    fpRegisterWriteStage fpRegisterWriteStage_inst (
        .ctrl         (ctrl),
        .reset        (reset),
        .stall        (stall),
        .clear        (clear),
        .prev         (resultBus.stage),
        .recovery     (recoveryBus.stage),
        .regWe        (regWe),
        .regNum       (regNum),
        .regData      (regData),
        .alWrite      (alWrite),
        .alWritePtr   (alWritePtr),
        .alWriteState (alWriteState),
        .alWriteFlags (alWriteFlags)
    );

    fpPhysRegFile fpPhysRegFile_inst (
        .ctrl   (ctrl),
        .reset  (reset),
        .we     (regWe),
        .wrNum  (regNum),
        .wrData (regData),
        .rdNum  (regReadNum),
        .rdData (regReadData)
    );

    activeListCompletion activeListCompletion_inst (
        .ctrl       (ctrl),
        .reset      (reset),
        .alloc      (alloc),
        .allocPtr   (allocPtr),
        .write      (alWrite),
        .writePtr   (alWritePtr),
        .writeState (alWriteState),
        .writeFlags (alWriteFlags),
        .queryPtr   (alQueryPtr),
        .queryState (alQueryState),
        .queryFlags (alQueryFlags)
    );

endmodule

//--- verilog/fpWriteback_defs.svh
/*
 * Sizing macros for the FP write-back slice.
 * FP_ISSUE_WIDTH may be 1, 2 or 4.
 * The *_BITS values must stay equal to log2 of their counts.
 */
`ifndef FP_WRITEBACK_DEFS_SVH
`define FP_WRITEBACK_DEFS_SVH

// Result lanes per cycle
`define FP_ISSUE_WIDTH 2

// Active list
`define AL_ENTRIES 16
`define AL_PTR_BITS 4

// Physical FP registers
`define FP_PHY_REGS 32
`define FP_REG_BITS 5

`endif

//--- verilog/recoveryIf.sv
/*
 * Recovery phase and selective-flush range.
 * Range is head inclusive to tail exclusive, empty when they match.
 */
`timescale 1ns/100ps

interface recoveryIf;
    import fpWritebackPkg::*;

    logic toRecoveryPhase;
    logic flushAll;
    AlPtr flushHead;
    AlPtr flushTail;

    modport source (
        output toRecoveryPhase, flushAll, flushHead, flushTail
    );

    modport stage (
        input toRecoveryPhase, flushAll, flushHead, flushTail
    );

endinterface
